/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --assert --timing
TOP       ?= tb_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) include/core_cfg.svh
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+include
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/regs.sv
rtl/exec_unit.sv
rtl/rib_bus.sv
rtl/core.sv
tb/tb_core.sv

/* include/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// pc after reset and after a debug restart
`define CORE_RESET_PC 32'h0000_0000

// address bit that steers a bus access to slave 1
`define CORE_SLAVE_SEL_BIT 28

// general purpose register count
`define CORE_REG_NUM 32

`endif

/* rtl/core.sv */
`timescale 1ns/1ns

module core (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  core_pkg::jtag_req_s  jtag_req_i,
    output logic [31:0]          jtag_rdata_o,
    input  logic                 jtag_halt_i,
    input  logic                 jtag_reset_i,
    output core_pkg::slave_req_s s0_req_o,
    input  logic [31:0]          s0_rdata_i,
    output core_pkg::slave_req_s s1_req_o,
    input  logic [31:0]          s1_rdata_i
);

    // fetch side
    logic [31:0]        fetch_addr;
    logic [31:0]        fetch_rdata;
    core_pkg::fetch_s   fetch;
    core_pkg::jump_s    jump;
    logic               bus_hold;

    // execute side
    logic [4:0]         rs1_addr;
    logic [31:0]        rs1_data;
    logic [4:0]         rs2_addr;
    logic [31:0]        rs2_data;
    core_pkg::reg_wr_s  reg_wr;
    core_pkg::mem_req_s mem_req;
    logic [31:0]        mem_rdata;

    fetch_unit u_fetch_unit (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .halt_i        (jtag_halt_i),
        .restart_i     (jtag_reset_i),
        .hold_i        (bus_hold),
        .jump_i        (jump),
        .fetch_addr_o  (fetch_addr),
        .fetch_rdata_i (fetch_rdata),
        .fetch_o       (fetch)
    );

    regs u_regs (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .rs1_addr_i   (rs1_addr),
        .rs1_data_o   (rs1_data),
        .rs2_addr_i   (rs2_addr),
        .rs2_data_o   (rs2_data),
        .wr_i         (reg_wr),
        .jtag_req_i   (jtag_req_i),
        .jtag_rdata_o (jtag_rdata_o)
    );

    exec_unit u_exec_unit (
        .fetch_i     (fetch),
        .rs1_addr_o  (rs1_addr),
        .rs1_data_i  (rs1_data),
        .rs2_addr_o  (rs2_addr),
        .rs2_data_i  (rs2_data),
        .wr_o        (reg_wr),
        .mem_o       (mem_req),
        .mem_rdata_i (mem_rdata),
        .jump_o      (jump)
    );

    rib_bus u_rib_bus (
        .fetch_addr_i  (fetch_addr),
        .fetch_rdata_o (fetch_rdata),
        .mem_i         (mem_req),
        .mem_rdata_o   (mem_rdata),
        .hold_o        (bus_hold),
        .s0_req_o      (s0_req_o),
        .s0_rdata_i    (s0_rdata_i),
        .s1_req_o      (s1_req_o),
        .s1_rdata_i    (s1_rdata_i)
    );

endmodule

/* rtl/core_pkg.sv */
package core_pkg;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_s;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_s;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_s;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_s;

    // one instruction word, viewed raw or through a format
    typedef union packed {
        logic [31:0] raw;
        r_fmt_s      r;
        i_fmt_s      i;
        s_fmt_s      s;
        b_fmt_s      b;
        u_fmt_s      u;
        j_fmt_s      j;
    } inst_u;

    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        inst_u       inst;
    } fetch_s;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_s;

    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } slave_req_s;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } reg_wr_s;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] wdata;
    } jtag_req_s;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } jump_s;

endpackage

/* rtl/exec_unit.sv */
`timescale 1ns/1ns

module exec_unit (
    input  core_pkg::fetch_s   fetch_i,
    output logic [4:0]         rs1_addr_o,
    input  logic [31:0]        rs1_data_i,
    output logic [4:0]         rs2_addr_o,
    input  logic [31:0]        rs2_data_i,
    output core_pkg::reg_wr_s  wr_o,
    output core_pkg::mem_req_s mem_o,
    input  logic [31:0]        mem_rdata_i,
    output core_pkg::jump_s    jump_o
);

    // funct fields of the supported subset
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    core_pkg::inst_u   inst;
    core_pkg::opcode_e opcode;
    logic [31:0]       imm_i;
    logic [31:0]       imm_s;
    logic [31:0]       imm_b;
    logic [31:0]       imm_u;
    logic [31:0]       imm_j;
    logic [31:0]       pc_plus4;
    logic              is_lw;
    logic              is_sw;

    assign inst   = fetch_i.inst;
    assign opcode = core_pkg::opcode_e'(inst.r.opcode);

    // rs1/rs2 sit in the same bits for every format that uses them
    assign rs1_addr_o = inst.r.rs1;
    assign rs2_addr_o = inst.r.rs2;

    // sign-extended immediates
    assign imm_i = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
    assign imm_s = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
    assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                    inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    assign imm_u = {inst.u.imm_31_12, 12'd0};
    assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                    inst.j.imm_11, inst.j.imm_10_1, 1'b0};

    assign pc_plus4 = fetch_i.pc + 32'd4;

    assign is_lw = fetch_i.valid && opcode == core_pkg::LOAD && inst.i.funct3 == F3_WORD;
    assign is_sw = fetch_i.valid && opcode == core_pkg::STORE && inst.s.funct3 == F3_WORD;

    // bus request, kept apart from the write-back path that uses the read data
    assign mem_o.req   = is_lw || is_sw;
    assign mem_o.we    = is_sw;
    assign mem_o.addr  = rs1_data_i + (is_sw ? imm_s : imm_i);
    assign mem_o.wdata = rs2_data_i;

    // register write-back
    always_comb begin
        wr_o = '0;
        if (fetch_i.valid) begin
            case (opcode)
                core_pkg::LUI: begin
                    wr_o.we   = 1'b1;
                    wr_o.addr = inst.u.rd;
                    wr_o.data = imm_u;
                end
                core_pkg::OP_IMM: begin
                    // addi only
                    wr_o.we   = (inst.i.funct3 == F3_ADD_SUB);
                    wr_o.addr = inst.i.rd;
                    wr_o.data = rs1_data_i + imm_i;
                end
                core_pkg::OP: begin
                    wr_o.we   = 1'b1;
                    wr_o.addr = inst.r.rd;
                    case ({inst.r.funct7, inst.r.funct3})
                        {F7_BASE, F3_ADD_SUB}: wr_o.data = rs1_data_i + rs2_data_i;
                        {F7_SUB, F3_ADD_SUB}:  wr_o.data = rs1_data_i - rs2_data_i;
                        {F7_BASE, F3_XOR}:     wr_o.data = rs1_data_i ^ rs2_data_i;
                        {F7_BASE, F3_OR}:      wr_o.data = rs1_data_i | rs2_data_i;
                        {F7_BASE, F3_AND}:     wr_o.data = rs1_data_i & rs2_data_i;
                        default:               wr_o.we   = 1'b0;
                    endcase
                end
                core_pkg::LOAD: begin
                    wr_o.we   = is_lw;
                    wr_o.addr = inst.i.rd;
                    wr_o.data = mem_rdata_i;
                end
                core_pkg::JAL: begin
                    wr_o.we   = 1'b1;
                    wr_o.addr = inst.j.rd;
                    wr_o.data = pc_plus4;
                end
                default: ;
            endcase
        end
    end

    // branch and jal redirect
    always_comb begin
        jump_o = '0;
        if (fetch_i.valid) begin
            case (opcode)
                core_pkg::BRANCH: begin
                    jump_o.target = fetch_i.pc + imm_b;
                    if (inst.b.funct3 == F3_BEQ) begin
                        jump_o.taken = (rs1_data_i == rs2_data_i);
                    end else if (inst.b.funct3 == F3_BNE) begin
                        jump_o.taken = (rs1_data_i != rs2_data_i);
                    end
                end
                core_pkg::JAL: begin
                    jump_o.taken  = 1'b1;
                    jump_o.target = fetch_i.pc + imm_j;
                end
                default: ;
            endcase
        end
    end

    // fetch assumes a load/store never redirects in the same cycle
    always_comb begin
        a_mem_jump_excl: assert (!(mem_o.req && jump_o.taken))
            else $error("memory request and jump in the same cycle");
    end

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ns

`include "core_cfg.svh"

module fetch_unit (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              halt_i,
    input  logic              restart_i,
    input  logic              hold_i,
    input  core_pkg::jump_s   jump_i,
    output logic [31:0]       fetch_addr_o,
    input  logic [31:0]       fetch_rdata_i,
    output core_pkg::fetch_s  fetch_o
);

    logic [31:0]     pc_q;
    logic            fetch_valid_q;
    logic [31:0]     fetch_pc_q;
    core_pkg::inst_u fetch_inst_q;
    logic            stall;

    // bus busy with a load/store, or debugger asked for a halt
    assign stall = halt_i || hold_i;

    assign fetch_addr_o = pc_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `CORE_RESET_PC;
        end else if (restart_i) begin
            pc_q <= `CORE_RESET_PC;
        end else if (jump_i.taken) begin
            pc_q <= jump_i.target;
        end else if (!stall) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // word fetched this cycle is only usable when nothing redirects or stalls
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_valid_q <= 1'b0;
        end else if (restart_i || jump_i.taken || stall) begin
            fetch_valid_q <= 1'b0;
        end else begin
            fetch_valid_q <= 1'b1;
        end
    end

    // payload follows the bus every cycle, qualified by valid
    always_ff @(posedge clk) begin
        fetch_pc_q   <= pc_q;
        fetch_inst_q <= fetch_rdata_i;
    end

    assign fetch_o.valid = fetch_valid_q;
    assign fetch_o.pc    = fetch_pc_q;
    assign fetch_o.inst  = fetch_inst_q;

    // jump targets come from exec, so this also covers bad branch offsets
    a_fetch_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        fetch_o.valid |-> (fetch_o.pc[1:0] == 2'b00)
    ) else $error("fetch pc 0x%08h not word aligned", fetch_o.pc);

endmodule

/* rtl/regs.sv */
`timescale 1ns/1ns

`include "core_cfg.svh"

module regs (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic [4:0]          rs1_addr_i,
    output logic [31:0]         rs1_data_o,
    input  logic [4:0]          rs2_addr_i,
    output logic [31:0]         rs2_data_o,
    input  core_pkg::reg_wr_s   wr_i,
    input  core_pkg::jtag_req_s jtag_req_i,
    output logic [31:0]         jtag_rdata_o
);

    logic [31:0] regs_q [`CORE_REG_NUM];

    // x0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `CORE_REG_NUM; i++) begin
                regs_q[i] <= 32'd0;
            end
        end else begin
            if (jtag_req_i.we && jtag_req_i.addr != 5'd0) begin
                regs_q[jtag_req_i.addr] <= jtag_req_i.wdata;
            end
            // later assignment wins when both hit the same register
            if (wr_i.we && wr_i.addr != 5'd0) begin
                regs_q[wr_i.addr] <= wr_i.data;
            end
        end
    end

    assign rs1_data_o   = regs_q[rs1_addr_i];
    assign rs2_data_o   = regs_q[rs2_addr_i];
    assign jtag_rdata_o = regs_q[jtag_req_i.addr];

    a_x0_zero: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        regs_q[0] == 32'd0
    ) else $error("x0 holds nonzero value 0x%08h", regs_q[0]);

endmodule

/* rtl/rib_bus.sv */
`timescale 1ns/1ns

`include "core_cfg.svh"

module rib_bus (
    input  logic [31:0]          fetch_addr_i,
    output logic [31:0]          fetch_rdata_o,
    input  core_pkg::mem_req_s   mem_i,
    output logic [31:0]          mem_rdata_o,
    output logic                 hold_o,
    output core_pkg::slave_req_s s0_req_o,
    input  logic [31:0]          s0_rdata_i,
    output core_pkg::slave_req_s s1_req_o,
    input  logic [31:0]          s1_rdata_i
);

    logic        ex_grant;
    logic [31:0] bus_addr;
    logic        sel_s1;
    logic        bus_we;
    logic [31:0] bus_rdata;

    // execute master always wins, fetch gets the bus otherwise
    assign ex_grant = mem_i.req;
    assign bus_addr = ex_grant ? mem_i.addr : fetch_addr_i;
    assign bus_we   = ex_grant && mem_i.we;
    assign sel_s1   = bus_addr[`CORE_SLAVE_SEL_BIT];

    // both slaves see address and data, only the selected one gets we
    assign s0_req_o.we    = bus_we && !sel_s1;
    assign s0_req_o.addr  = bus_addr;
    assign s0_req_o.wdata = mem_i.wdata;
    assign s1_req_o.we    = bus_we && sel_s1;
    assign s1_req_o.addr  = bus_addr;
    assign s1_req_o.wdata = mem_i.wdata;

    assign bus_rdata = sel_s1 ? s1_rdata_i : s0_rdata_i;

    assign mem_rdata_o   = ex_grant ? bus_rdata : 32'd0;
    assign fetch_rdata_o = ex_grant ? 32'd0 : bus_rdata;

    // fetch loses this cycle whenever execute owns the bus
    assign hold_o = ex_grant;

    always_comb begin
        a_one_slave_we: assert (!(s0_req_o.we && s1_req_o.we))
            else $error("write enable on both slaves");
    end

endmodule

/* tb/tb_core.sv */
`timescale 1ns/1ns

`include "core_cfg.svh"

module tb_core;

    localparam logic [31:0] DONE_ADDR = 32'h1000_03FC;
    localparam logic [31:0] S1_BASE   = 32'h1000_0000;
    localparam int          TIMEOUT   = 4000;

    logic                 clk;
    logic                 arst_n;
    core_pkg::jtag_req_s  jtag_req;
    logic [31:0]          jtag_rdata;
    logic                 jtag_halt;
    logic                 jtag_reset;
    core_pkg::slave_req_s s0_req;
    logic [31:0]          s0_rdata;
    core_pkg::slave_req_s s1_req;
    logic [31:0]          s1_rdata;

    logic [31:0] mem0 [1024];
    logic [31:0] mem1 [1024];

    // slave 1 stores in arrival order without the done marker
    core_pkg::slave_req_s stores [$];
    logic [31:0]          exp_addr [$];
    logic [31:0]          exp_data [$];
    logic [31:0]          prog [$];
    logic                 done_seen;
    int                   s0_we_count;

    int errors;
    int checks;
    int tests;
    int failed_tests;
    int test_err_start;

    core u_core (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .jtag_req_i   (jtag_req),
        .jtag_rdata_o (jtag_rdata),
        .jtag_halt_i  (jtag_halt),
        .jtag_reset_i (jtag_reset),
        .s0_req_o     (s0_req),
        .s0_rdata_i   (s0_rdata),
        .s1_req_o     (s1_req),
        .s1_rdata_i   (s1_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // both slaves answer in the same cycle
    assign s0_rdata = mem0[s0_req.addr[11:2]];
    assign s1_rdata = mem1[s1_req.addr[11:2]];

    always @(posedge clk) begin
        if (s0_req.we) begin
            mem0[s0_req.addr[11:2]] <= s0_req.wdata;
            s0_we_count = s0_we_count + 1;
        end
        if (s1_req.we) begin
            mem1[s1_req.addr[11:2]] <= s1_req.wdata;
            if (s1_req.addr == DONE_ADDR) begin
                done_seen = 1'b1;
            end else begin
                stores.push_back(s1_req);
            end
        end
    end

    // instruction encoders
    function automatic logic [31:0] enc_lui(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_alu(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                            logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_lw(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                               logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] pc_of_next();
        return `CORE_RESET_PC + prog.size() * 4;
    endfunction

    // compare tasks
    task automatic check_word(logic [31:0] got, logic [31:0] exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_store(core_pkg::slave_req_s got, logic [31:0] addr, logic [31:0] data,
                               string what);
        checks++;
        if (got.we !== 1'b1 || got.addr !== addr || got.wdata !== data) begin
            errors++;
            $display("FAIL at %0t ns: %s is 0x%08h <= 0x%08h, expected 0x%08h <= 0x%08h",
                     $time, what, got.addr, got.wdata, addr, data);
        end
    endtask

    task automatic check_reg(logic [4:0] idx, logic [31:0] exp);
        @(negedge clk);
        jtag_req = '{we: 1'b0, addr: idx, wdata: 32'd0};
        #1;
        check_word(jtag_rdata, exp, $sformatf("register x%0d", idx));
    endtask

    task automatic write_reg(logic [4:0] idx, logic [31:0] val);
        @(negedge clk);
        jtag_req = '{we: 1'b1, addr: idx, wdata: val};
        @(negedge clk);
        jtag_req.we = 1'b0;
    endtask

    task automatic expect_store(logic [31:0] addr, logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic check_stores();
        check_word(stores.size(), exp_addr.size(), "store count");
        for (int i = 0; i < exp_addr.size() && i < stores.size(); i++) begin
            check_store(stores[i], exp_addr[i], exp_data[i], $sformatf("store %0d", i));
        end
        exp_addr.delete();
        exp_data.delete();
    endtask

    // program handling
    task automatic end_program();
        prog.push_back(enc_sw(5'd0, 5'd31, 12'h3FC));
        prog.push_back(enc_jal(5'd0, 21'd0));
    endtask

    task automatic load_program();
        for (int i = 0; i < 1024; i++) begin
            mem0[i] = (i < prog.size()) ? prog[i] : (32'hA500_0000 ^ (i << 2));
        end
    endtask

    task automatic restart_core();
        @(negedge clk);
        stores.delete();
        done_seen   = 1'b0;
        jtag_halt   = 1'b0;
        jtag_reset  = 1'b1;
        @(negedge clk);
        jtag_reset  = 1'b0;
    endtask

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic wait_done(string name);
        int n;
        n = 0;
        while (!done_seen && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!done_seen) begin
            abort_run($sformatf("timeout: no done store after %0d cycles in %s", n, name));
        end
    endtask

    task automatic wait_stores(int count, string name);
        int n;
        n = 0;
        while (stores.size() < count && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (stores.size() < count) begin
            abort_run($sformatf("timeout: fewer than %0d stores seen in %s", count, name));
        end
    endtask

    task automatic halt_core();
        @(negedge clk);
        jtag_halt = 1'b1;
        repeat (2) @(negedge clk);
    endtask

    task automatic run_program(string name);
        load_program();
        restart_core();
        wait_done(name);
        halt_core();
    endtask

    task automatic begin_test();
        test_err_start = errors;
        prog.delete();
        tests++;
    endtask

    task automatic end_test(string name);
        if (errors == test_err_start) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - test_err_start);
        end
    endtask

    // directed tests
    task automatic test_reset_state();
        begin_test();
        repeat (10) @(negedge clk);
        check_word(s0_we_count, 0, "s0 write count");
        check_word(stores.size() + done_seen, 0, "s1 write count");
        for (int i = 0; i < 32; i++) begin
            check_reg(i[4:0], 32'd0);
        end
        end_test("reset_state");
    endtask

    task automatic test_debug_access();
        logic [31:0] vals [32];
        begin_test();
        for (int i = 1; i < 32; i++) begin
            vals[i] = $urandom;
            write_reg(i[4:0], vals[i]);
        end
        for (int i = 1; i < 32; i++) begin
            check_reg(i[4:0], vals[i]);
        end
        write_reg(5'd0, 32'hFFFF_FFFF);
        check_reg(5'd0, 32'd0);
        end_test("debug_access");
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [19:0] up;
        logic [11:0] neg;
        logic [11:0] pos;
        logic [31:0] res [11];
        begin_test();
        a   = $urandom;
        b   = $urandom;
        up  = 20'($urandom);
        neg = {1'b1, 11'($urandom)};
        pos = {1'b0, 11'($urandom)};
        write_reg(5'd1, a);
        write_reg(5'd2, b);
        res[3]  = {up, 12'd0};
        res[4]  = a + {{20{1'b1}}, neg};
        res[5]  = a + b;
        res[6]  = a - b;
        res[7]  = a & b;
        res[8]  = a | b;
        res[9]  = a ^ b;
        res[10] = b + {20'd0, pos};
        prog.push_back(enc_lui(5'd31, 20'h10000));
        prog.push_back(enc_lui(5'd3, up));
        prog.push_back(enc_addi(5'd4, 5'd1, neg));
        prog.push_back(enc_alu(7'h00, 3'b000, 5'd5, 5'd1, 5'd2));
        prog.push_back(enc_alu(7'h20, 3'b000, 5'd6, 5'd1, 5'd2));
        prog.push_back(enc_alu(7'h00, 3'b111, 5'd7, 5'd1, 5'd2));
        prog.push_back(enc_alu(7'h00, 3'b110, 5'd8, 5'd1, 5'd2));
        prog.push_back(enc_alu(7'h00, 3'b100, 5'd9, 5'd1, 5'd2));
        prog.push_back(enc_addi(5'd10, 5'd2, pos));
        for (int r = 3; r <= 10; r++) begin
            prog.push_back(enc_sw(r[4:0], 5'd31, 12'((r - 3) * 4)));
            expect_store(S1_BASE + (r - 3) * 4, res[r]);
        end
        end_program();
        run_program("alu");
        check_stores();
        for (int r = 3; r <= 10; r++) begin
            check_reg(r[4:0], res[r]);
        end
        end_test("alu");
    endtask

    task automatic test_load_store();
        logic [31:0] d0;
        logic [31:0] d1;
        int          base_we;
        begin_test();
        d0 = $urandom;
        d1 = $urandom;
        write_reg(5'd1, d1);
        prog.push_back(enc_lui(5'd31, 20'h10000));
        prog.push_back(enc_sw(5'd1, 5'd31, 12'h008));
        prog.push_back(enc_lw(5'd2, 5'd31, 12'h008));
        prog.push_back(enc_lw(5'd3, 5'd0, 12'h320));
        prog.push_back(enc_sw(5'd3, 5'd31, 12'h00C));
        end_program();
        load_program();
        // preloaded data word in slave 0
        mem0[200] = d0;
        base_we   = s0_we_count;
        restart_core();
        wait_done("load_store");
        halt_core();
        expect_store(S1_BASE + 32'h8, d1);
        expect_store(S1_BASE + 32'hC, d0);
        check_stores();
        check_word(s0_we_count - base_we, 0, "s0 write count");
        check_reg(5'd2, d1);
        check_reg(5'd3, d0);
        end_test("load_store");
    endtask

    task automatic test_branches();
        logic [11:0] n;
        logic [31:0] link;
        begin_test();
        n = 12'(3 + $urandom % 20);
        prog.push_back(enc_lui(5'd31, 20'h10000));
        prog.push_back(enc_addi(5'd1, 5'd0, 12'd0));
        prog.push_back(enc_addi(5'd2, 5'd0, n));
        prog.push_back(enc_addi(5'd1, 5'd1, 12'd1));
        prog.push_back(enc_branch(3'b001, 5'd1, 5'd2, -13'sd4));
        prog.push_back(enc_branch(3'b000, 5'd0, 5'd0, 13'd8));
        // skipped by the beq
        prog.push_back(enc_sw(5'd1, 5'd31, 12'h010));
        link = pc_of_next() + 32'd4;
        prog.push_back(enc_jal(5'd5, 21'd8));
        // skipped by the jal
        prog.push_back(enc_sw(5'd2, 5'd31, 12'h014));
        prog.push_back(enc_sw(5'd1, 5'd31, 12'h018));
        end_program();
        run_program("branches");
        expect_store(S1_BASE + 32'h18, {20'd0, n});
        check_stores();
        check_reg(5'd1, {20'd0, n});
        check_reg(5'd5, link);
        end_test("branches");
    endtask

    task automatic test_halt_restart();
        logic [11:0] v1;
        logic [11:0] v2;
        int          frozen;
        begin_test();
        v1 = 12'($urandom % 2048);
        v2 = 12'($urandom % 2048);
        prog.push_back(enc_lui(5'd31, 20'h10000));
        prog.push_back(enc_addi(5'd1, 5'd0, v1));
        prog.push_back(enc_sw(5'd1, 5'd31, 12'h020));
        prog.push_back(enc_addi(5'd2, 5'd0, v2));
        prog.push_back(enc_sw(5'd2, 5'd31, 12'h024));
        prog.push_back(enc_addi(5'd3, 5'd0, 12'd0));
        prog.push_back(enc_addi(5'd4, 5'd0, 12'd30));
        prog.push_back(enc_addi(5'd3, 5'd3, 12'd1));
        prog.push_back(enc_branch(3'b001, 5'd3, 5'd4, -13'sd4));
        prog.push_back(enc_sw(5'd3, 5'd31, 12'h028));
        end_program();
        load_program();
        restart_core();
        wait_stores(1, "halt_restart");
        @(negedge clk);
        jtag_halt = 1'b1;
        // the instruction already registered may still finish
        @(negedge clk);
        frozen = stores.size();
        repeat (20) @(negedge clk);
        check_word(stores.size(), frozen, "store count while halted");
        jtag_halt = 1'b0;
        wait_done("halt_restart");
        halt_core();
        expect_store(S1_BASE + 32'h20, {20'd0, v1});
        expect_store(S1_BASE + 32'h24, {20'd0, v2});
        expect_store(S1_BASE + 32'h28, 32'd30);
        check_stores();
        restart_core();
        wait_done("halt_restart rerun");
        halt_core();
        expect_store(S1_BASE + 32'h20, {20'd0, v1});
        expect_store(S1_BASE + 32'h24, {20'd0, v2});
        expect_store(S1_BASE + 32'h28, 32'd30);
        check_stores();
        end_test("halt_restart");
    endtask

    initial begin
        void'($urandom(32'hd3e8));
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        s0_we_count  = 0;
        done_seen    = 1'b0;
        arst_n       = 1'b0;
        jtag_req     = '0;
        jtag_halt    = 1'b1;
        jtag_reset   = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            mem0[i] = 32'hA500_0000 ^ (i << 2);
            mem1[i] = 32'h5A00_0000 ^ (i << 2);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_reset_state();
        test_debug_access();
        test_alu();
        test_load_store();
        test_branches();
        test_halt_restart();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
